/* routerOutput.f */
rtl/flitPkg.sv
rtl/arbPkg.sv
rtl/flitQueue.sv
rtl/grantTimer.sv
rtl/portArbiter.sv
rtl/outputLink.sv
rtl/routerOutput.sv
verif/routerOutputTb.sv

/* run.sh */
#!/bin/sh
# Build and run the router output testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f routerOutput.f --top-module routerOutputTb \
  -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || true
grep -q "Regression passed" sim.log && exit 0 || exit 1

/* verif/routerOutputTb.sv */
module routerOutputTb
  import flitPkg::*;
  import arbPkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifoDepth = 4;
  localparam int clkPeriod = 8;
  localparam int randCycles = 150;
  localparam int drainLimit = 200;
  localparam int stimCycles = 3 + 10 + 20 + randCycles + 3 * drainLimit;

  typedef logic [flitIdWidth+lengthWidth+dataWidth-1:0] flitT;

  logic                   clk;
  logic                   rst;
  logic                   inWrite  [numPorts];
  logic [flitIdWidth-1:0] inFlitId [numPorts];
  logic [lengthWidth-1:0] inLength [numPorts];
  logic [dataWidth-1:0]   inData   [numPorts];
  logic                   inFull   [numPorts];
  logic                   outValid;
  logic [portWidth-1:0]   outPort;
  logic [flitIdWidth-1:0] outFlitId;
  logic [lengthWidth-1:0] outLength;
  logic [dataWidth-1:0]   outData;

  flitT refQ [numPorts][$];            // Flits accepted by each queue, oldest first
  int   lenOf [numPorts] = '{6, 1, 3, 0, 2};
  int   pktPos [numPorts];
  int   seqNum [numPorts];
  int   hdrLen [numPorts];
  int   occ [numPorts];                // Occupancy of each DUT queue after the last edge
  logic [numPorts-1:0] wrPrev;
  logic [numPorts-1:0] reqD1;
  logic [numPorts-1:0] reqD2;
  logic                prevValid;
  logic [portWidth-1:0] prevPort;
  int   runLen;
  int   errors;
  int   checks;
  int   seed;
  logic anyWrite;

  routerOutput #(.fifoDepth(fifoDepth)) dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #(stimCycles * clkPeriod + 500);
    $display("Watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

  // Nothing may leave the router before anything has entered it
  assert property (@(posedge clk) disable iff (rst) !anyWrite |-> !outValid)
  else
  begin
    errors++;
    $display("Error at %0t ns: outValid high before any write", $time);
  end

  function automatic int nextWaiting(input int from, input logic [numPorts-1:0] r);
    int idx;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (from + k) % numPorts;
      if (r[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic int pendingTotal();
    int n;
    n = 0;
    for (int p = 0; p < numPorts; p++)
      n += refQ[p].size();
    return n;
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
    for (int p = 0; p < numPorts; p++)
      inWrite[p] = 1'b0;
  endtask

  // Next flit of a three-flit packet, counted only when the queue can take it
  task automatic writeFlit(input int p);
    logic [flitIdWidth-1:0] kind;
    logic [dataWidth-1:0]   data;
    kind = (pktPos[p] == 0) ? flitHead : (pktPos[p] == 1) ? flitBody : flitTail;
    data = {3'(p), 13'(seqNum[p])};
    inWrite[p]  = 1'b1;
    inFlitId[p] = kind;
    inLength[p] = lengthWidth'(lenOf[p]);
    inData[p]   = data;
    anyWrite    = 1'b1;
    if (!inFull[p])
    begin
      refQ[p].push_back({kind, lengthWidth'(lenOf[p]), data});
      pktPos[p] = (pktPos[p] + 1) % 3;
      seqNum[p]++;
    end
  endtask

  task automatic waitDrain();
    int n;
    n = 0;
    while (pendingTotal() > 0 && n < drainLimit)
    begin
      nextCycle();
      n++;
    end
  endtask

  always @(posedge clk)
  begin : scoreboard
    logic [numPorts-1:0] reqNow;
    logic                others;
    int                  expPort;
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        occ[p] = occ[p] + int'(wrPrev[p]) - ((outValid && outPort == portWidth'(p)) ? 1 : 0);
        wrPrev[p] = inWrite[p] && !inFull[p];
        reqNow[p] = occ[p] > 0;
      end
      if (outValid)
      begin
        checks++;
        others = 1'b0;
        for (int q = 0; q < numPorts; q++)
          if (q != int'(outPort) && reqD2[q])
            others = 1'b1;
        if (prevValid && outPort != prevPort)
        begin
          expPort = nextWaiting(int'(prevPort), reqD2);
          assert (int'(outPort) == expPort)
          else
          begin
            errors++;
            $display("Error at %0t ns: grant went to port %0d, expected %0d",
                     $time, outPort, expPort);
          end
        end
        if (outFlitId == flitHead)
          hdrLen[outPort] = int'(outLength);
        runLen = !others ? 0 : (prevValid && outPort == prevPort) ? runLen + 1 : 1;
        assert (runLen <= hdrLen[outPort] + 1)
        else
        begin
          errors++;
          $display("Error at %0t ns: port %0d held the output %0d cycles",
                   $time, outPort, runLen);
        end
        assert (refQ[outPort].size() > 0 && refQ[outPort][0] == {outFlitId, outLength, outData})
        else
        begin
          errors++;
          $display("Error at %0t ns: unexpected flit %h on port %0d",
                   $time, {outFlitId, outLength, outData}, outPort);
        end
        if (refQ[outPort].size() > 0)
          void'(refQ[outPort].pop_front());
      end
      prevValid = outValid;
      prevPort  = outPort;
      reqD2     = reqD1;
      reqD1     = reqNow;
    end
  end

  initial
  begin
    seed = 19115;
    errors = 0;
    checks = 0;
    anyWrite = 1'b0;
    prevValid = 1'b0;
    prevPort = '0;
    runLen = 0;
    wrPrev = '0;
    reqD1 = '0;
    reqD2 = '0;
    rst = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      inWrite[p] = 1'b0;
      inFlitId[p] = '0;
      inLength[p] = '0;
      inData[p] = '0;
      pktPos[p] = 0;
      seqNum[p] = 0;
      hdrLen[p] = 4095;
      occ[p] = 0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    repeat (3) nextCycle();

    // Lone header into an idle router takes exactly two cycles
    writeFlit(portNorth);
    nextCycle(); // The queue takes the header at this edge
    nextCycle();
    assert (!outValid)
    else
    begin
      errors++;
      $display("Error at %0t ns: output one cycle early", $time);
    end
    nextCycle();
    checks++;
    assert (outValid && outPort == portNorth && outFlitId == flitHead)
    else
    begin
      errors++;
      $display("Error at %0t ns: North header not on the output after 2 cycles", $time);
    end
    waitDrain();

    // Local holds the grant while West fills up behind it
    for (int i = 0; i < fifoDepth + 8; i++)
    begin
      if (i == fifoDepth)
      begin
        checks++;
        assert (inFull[portWest])
        else
        begin
          errors++;
          $display("Error at %0t ns: West not full", $time);
        end
      end
      writeFlit(portLocal);
      if (i < fifoDepth + 2)
        writeFlit(portWest);
      nextCycle();
    end
    waitDrain();

    // L and E never run dry while the other ports write at random
    for (int c = 0; c < randCycles; c++)
    begin
      writeFlit(portLocal);
      writeFlit(portEast);
      for (int p = portNorth; p <= portSouth; p++)
        if (p != portEast && $random(seed) % 4 == 0)
          writeFlit(p);
      nextCycle();
    end
    waitDrain();
    repeat (4) nextCycle();

    for (int p = 0; p < numPorts; p++)
    begin
      checks++;
      assert (refQ[p].size() == 0)
      else
      begin
        errors++;
        $display("Error at %0t ns: %0d flits of port %0d never came out",
                 $time, refQ[p].size(), p);
      end
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* rtl/routerOutput.sv */
module routerOutput
  import flitPkg::*;
  import arbPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inWrite  [numPorts],
  input  logic [flitIdWidth-1:0] inFlitId [numPorts],
  input  logic [lengthWidth-1:0] inLength [numPorts],
  input  logic [dataWidth-1:0]   inData   [numPorts],
  output logic                   inFull   [numPorts],
  output logic                   outValid,
  output logic [portWidth-1:0]   outPort,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [lengthWidth-1:0] outLength,
  output logic [dataWidth-1:0]   outData
);

  logic [flitIdWidth-1:0] headFlitId [numPorts];
  logic [lengthWidth-1:0] headLength [numPorts];
  logic [dataWidth-1:0]   headData   [numPorts];
  logic                   notEmpty   [numPorts];
  logic                   pop        [numPorts];
  logic [stateWidth-1:0]  grant;

  for (genvar p = 0; p < numPorts; p++)
  begin : genQueue
    flitQueue #(
      .fifoDepth (fifoDepth)
    ) queue (
      .clk        (clk),
      .rst        (rst),
      .write      (inWrite[p]),
      .wrFlitId   (inFlitId[p]),
      .wrLength   (inLength[p]),
      .wrData     (inData[p]),
      .pop        (pop[p]),
      .headFlitId (headFlitId[p]),
      .headLength (headLength[p]),
      .headData   (headData[p]),
      .notEmpty   (notEmpty[p]),
      .full       (inFull[p])
    );
  end

  // A queue holding a flit is a request for the output
  portArbiter arbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (notEmpty),
    .headFlitId (headFlitId),
    .headLength (headLength),
    .grant      (grant)
  );

  outputLink link (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .notEmpty   (notEmpty),
    .headFlitId (headFlitId),
    .headLength (headLength),
    .headData   (headData),
    .pop        (pop),
    .outValid   (outValid),
    .outPort    (outPort),
    .outFlitId  (outFlitId),
    .outLength  (outLength),
    .outData    (outData)
  );

endmodule

/* rtl/outputLink.sv */
module outputLink
  import flitPkg::*;
  import arbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [stateWidth-1:0]  grant,
  input  logic                   notEmpty   [numPorts],
  input  logic [flitIdWidth-1:0] headFlitId [numPorts],
  input  logic [lengthWidth-1:0] headLength [numPorts],
  input  logic [dataWidth-1:0]   headData   [numPorts],
  output logic                   pop        [numPorts],
  output logic                   outValid,
  output logic [portWidth-1:0]   outPort,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [lengthWidth-1:0] outLength,
  output logic [dataWidth-1:0]   outData
);

  logic [portWidth-1:0] selPort;
  logic                 granted;
  logic                 take;

  // Bit 0 of grant is idle, so port p sits at bit p+1
  always_comb
  begin
    selPort = '0;
    granted = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p+1])
      begin
        selPort = portWidth'(p);
        granted = 1'b1;
      end
    end
  end

  assign take = granted && notEmpty[selPort];

  for (genvar p = 0; p < numPorts; p++)
  begin : genPop
    assign pop[p] = take && (selPort == portWidth'(p));
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= take;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outPort   <= selPort;
      outFlitId <= headFlitId[selPort];
      outLength <= headLength[selPort];
      outData   <= headData[selPort];
    end
  end

endmodule

/* rtl/portArbiter.sv */
module portArbiter
  import flitPkg::*;
  import arbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req        [numPorts],
  input  logic [flitIdWidth-1:0] headFlitId [numPorts],
  input  logic [lengthWidth-1:0] headLength [numPorts],
  output logic [stateWidth-1:0]  grant
);

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0]   reqVec;
  logic [numPorts-1:0]   runTimer;
  logic [numPorts-1:0]   timesUp;
  logic [portWidth-1:0]  curPort;
  logic                  busy;

  function automatic logic [stateWidth-1:0] portState(input logic [portWidth-1:0] port);
    logic [stateWidth-1:0] code;
    case (port)
      portLocal: code = stL;
      portNorth: code = stN;
      portEast:  code = stE;
      portWest:  code = stW;
      portSouth: code = stS;
      default:   code = stIdle;
    endcase
    return code;
  endfunction

  // First requester after from, wrapping round to from itself last
  function automatic logic [stateWidth-1:0] firstAfter(input logic [portWidth-1:0] from,
                                                       input logic [numPorts-1:0] r);
    logic [stateWidth-1:0] result;
    logic                  found;
    int                    idx;
    result = stIdle;
    found  = 1'b0;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (int'(from) + k) % numPorts;
      if (r[idx] && !found)
      begin
        result = portState(portWidth'(idx));
        found  = 1'b1;
      end
    end
    return result;
  endfunction

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    assign reqVec[p] = req[p];

    grantTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (headFlitId[p]),
      .length   (headLength[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  always_comb
  begin
    busy    = 1'b1;
    curPort = portLocal;
    case (state)
      stL:     curPort = portLocal;
      stN:     curPort = portNorth;
      stE:     curPort = portEast;
      stW:     curPort = portWest;
      stS:     curPort = portSouth;
      default: busy = 1'b0; // Idle, and any broken code recovers through the idle search
    endcase
  end

  always_comb
  begin
    runTimer = '0;
    if (!busy)
      nextState = firstAfter(portSouth, reqVec); // Search from after S starts at L
    else if (reqVec[curPort] && !timesUp[curPort])
    begin
      nextState         = state;
      runTimer[curPort] = 1'b1;
    end
    else
      nextState = firstAfter(curPort, reqVec);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  assign grant = state;

endmodule

/* rtl/grantTimer.sv */
module grantTimer
  import flitPkg::*;
  import arbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [timerWidth-1:0] timeoutLength;
  logic [timerWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeoutLength <= '0;
      count         <= '0;
    end
    else
    begin
      if (flitId == flitHead)
        timeoutLength <= length; // Last header seen at the queue head sets the limit
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == timeoutLength);

endmodule

/* rtl/flitQueue.sv */
module flitQueue
  import flitPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   write,
  input  logic [flitIdWidth-1:0] wrFlitId,
  input  logic [lengthWidth-1:0] wrLength,
  input  logic [dataWidth-1:0]   wrData,
  input  logic                   pop,
  output logic [flitIdWidth-1:0] headFlitId,
  output logic [lengthWidth-1:0] headLength,
  output logic [dataWidth-1:0]   headData,
  output logic                   notEmpty,
  output logic                   full
);

  localparam int ptrWidth = $clog2(fifoDepth);

  logic [flitIdWidth-1:0] memFlitId [fifoDepth];
  logic [lengthWidth-1:0] memLength [fifoDepth];
  logic [dataWidth-1:0]   memData   [fifoDepth];

  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth:0]   count;
  logic                doWrite;
  logic                doPop;

  assign notEmpty = (count != '0);
  assign full     = (count == (ptrWidth+1)'(fifoDepth));
  assign doWrite  = write && !full; // A write into a full queue is lost
  assign doPop    = pop && notEmpty;

  assign headFlitId = memFlitId[rdPtr];
  assign headLength = memLength[rdPtr];
  assign headData   = memData[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      memFlitId[wrPtr] <= wrFlitId;
      memLength[wrPtr] <= wrLength;
      memData[wrPtr]   <= wrData;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      if (doWrite && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doWrite)
        count <= count - 1'b1;
    end
  end

endmodule

/* rtl/arbPkg.sv */
package arbPkg;

  localparam int numPorts = 5;
  localparam int portWidth = 3;

  // Rotation order is the index order
  localparam logic [portWidth-1:0] portLocal = 3'd0;
  localparam logic [portWidth-1:0] portNorth = 3'd1;
  localparam logic [portWidth-1:0] portEast  = 3'd2;
  localparam logic [portWidth-1:0] portWest  = 3'd3;
  localparam logic [portWidth-1:0] portSouth = 3'd4;

  // One-hot arbiter states, idle in bit 0 and port p in bit p+1
  localparam int stateWidth = 6;

  localparam logic [stateWidth-1:0] stIdle = 6'b000001;
  localparam logic [stateWidth-1:0] stL    = 6'b000010;
  localparam logic [stateWidth-1:0] stN    = 6'b000100;
  localparam logic [stateWidth-1:0] stE    = 6'b001000;
  localparam logic [stateWidth-1:0] stW    = 6'b010000;
  localparam logic [stateWidth-1:0] stS    = 6'b100000;

  // The grant timer counts up to a header length
  localparam int timerWidth = flitPkg::lengthWidth;

endpackage

/* rtl/flitPkg.sv */
package flitPkg;

  // Flit kind, carried with every flit
  localparam int flitIdWidth = 3;

  localparam logic [flitIdWidth-1:0] flitHead = 3'd1;
  localparam logic [flitIdWidth-1:0] flitBody = 3'd2;
  localparam logic [flitIdWidth-1:0] flitTail = 3'd3;

  // A header's length is the number of extra cycles its port may keep the output
  localparam int lengthWidth = 12;

  localparam int dataWidth = 16;

endpackage
